// ==== include/mdio_defs.svh ====
`ifndef MDIO_DEFS_SVH
`define MDIO_DEFS_SVH

// ENETA_RX_CLK cycles per MDC half period
`define MDC_HALF_PERIOD 5

// wait after reset before the first management frame
`define PHY_POWERUP_CYCLES 1000

// PHY address and register range
`define PHY_ADDR 5'd0
`define PHY_REG_COUNT 32

// clause-22 read frame fields
`define MDIO_PREAMBLE_BITS 32
`define MDIO_OP_READ 4'b0110

// memory dump layout
`define DUMP_WRITES_PER_REG 10
`define DUMP_GAP_CYCLES 6
`define MEM_DEPTH 4096
`define DUMP_TAG 4'hA

`endif

// ==== src/mdio_pkg.sv ====
package mdio_pkg;

    ////////////////////////////////////////////////////////////////////
    // management data widths
    ////////////////////////////////////////////////////////////////////

    // one PHY register value
    typedef logic [15:0] phy_data_t;
    typedef logic [4:0]  phy_reg_addr_t;
    typedef logic [4:0]  phy_addr_t;

    ////////////////////////////////////////////////////////////////////
    // on-chip memory write port
    ////////////////////////////////////////////////////////////////////

    typedef logic [11:0] mem_addr_t;
    typedef logic [31:0] mem_word_t;

    // strobe, word address and data of one memory write
    typedef struct packed {
        logic      wr;
        mem_addr_t addr;
        mem_word_t data;
    } mem_wr_t;

    // phases of one clause-22 read frame
    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        COMMAND,
        TURNAROUND,
        DATA,
        DONE
    } mdio_state_t;

endpackage

// ==== src/mdc_clock_gen.sv ====
`timescale 1ns/1ps
`include "mdio_defs.svh"

module mdc_clock_gen (
    input  logic ENETA_RX_CLK,
    input  logic CPU_RESETn,
    output logic mdc,
    output logic mdc_rise,
    output logic mdc_fall
);

    localparam int half_period = `MDC_HALF_PERIOD;
    localparam int cnt_w = (half_period > 1) ? $clog2(half_period) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(half_period - 1);

    logic [cnt_w-1:0] div_cnt;
    logic             edge_due;

    // mdc flips on the clock edge that ends this cycle
    assign edge_due = (div_cnt == cnt_last);
    assign mdc_rise = edge_due && !mdc;
    assign mdc_fall = edge_due && mdc;

    always_ff @(posedge ENETA_RX_CLK) begin
        if (!CPU_RESETn) begin
            div_cnt <= '0;
            mdc     <= 1'b0;
        end else if (edge_due) begin
            div_cnt <= '0;
            mdc     <= !mdc;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // a fall strobe follows each rise strobe one half period later
    a_rise_then_fall: assert property (
        @(posedge ENETA_RX_CLK) disable iff (!CPU_RESETn)
        mdc_rise |-> ##half_period mdc_fall
    );

endmodule

// ==== src/mdio_read_engine.sv ====
`timescale 1ns/1ps
`include "mdio_defs.svh"

module mdio_read_engine
    import mdio_pkg::*;
(
    input  logic          ENETA_RX_CLK,
    input  logic          CPU_RESETn,
    input  logic          mdc_rise,
    input  logic          mdc_fall,
    input  logic          start,
    input  phy_reg_addr_t reg_addr,
    input  logic          mdio_in,
    output logic          mdio_out,
    output logic          mdio_oe,
    output logic          done,
    output phy_data_t     rd_data
);

    localparam phy_addr_t phy_addr = `PHY_ADDR;
    localparam int cmd_bits = 4 + $bits(phy_addr_t) + $bits(phy_reg_addr_t);
    localparam logic [5:0] preamble_len = 6'(`MDIO_PREAMBLE_BITS);
    localparam logic [5:0] cmd_len = 6'(cmd_bits);
    localparam logic [5:0] ta_len = 6'd2;
    localparam logic [5:0] data_last = 6'($bits(phy_data_t) - 1);

    mdio_state_t         state;
    logic [5:0]          bit_cnt;
    logic [cmd_bits-1:0] cmd_sr;
    phy_data_t           data_sr;
    logic                cmd_shift;

    // a command bit goes out on this fall
    assign cmd_shift = mdc_fall &&
                       ((state == PREAMBLE && bit_cnt == preamble_len) ||
                        (state == COMMAND && bit_cnt != cmd_len));

    ////////////////////////////////////////////////////////////////////
    // frame sequencing, each phase starts on an mdc fall
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge ENETA_RX_CLK) begin
        if (!CPU_RESETn) begin
            state    <= IDLE;
            bit_cnt  <= '0;
            mdio_out <= 1'b0;
            mdio_oe  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= PREAMBLE;
                        bit_cnt <= '0;
                    end
                end
                PREAMBLE: begin
                    if (mdc_fall) begin
                        mdio_oe <= 1'b1;
                        if (bit_cnt == preamble_len) begin
                            state    <= COMMAND;
                            bit_cnt  <= 6'd1;
                            mdio_out <= cmd_sr[cmd_bits-1];
                        end else begin
                            mdio_out <= 1'b1;
                            bit_cnt  <= bit_cnt + 1'b1;
                        end
                    end
                end
                COMMAND: begin
                    if (mdc_fall) begin
                        if (bit_cnt == cmd_len) begin
                            // hand the line to the PHY
                            state    <= TURNAROUND;
                            bit_cnt  <= 6'd1;
                            mdio_oe  <= 1'b0;
                            mdio_out <= 1'b0;
                        end else begin
                            mdio_out <= cmd_sr[cmd_bits-1];
                            bit_cnt  <= bit_cnt + 1'b1;
                        end
                    end
                end
                TURNAROUND: begin
                    if (mdc_fall) begin
                        if (bit_cnt == ta_len) begin
                            state   <= DATA;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                DATA: begin
                    if (mdc_rise) begin
                        if (bit_cnt == data_last) begin
                            state <= DONE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // command word shifts out msb first, read data shifts in msb first
    always_ff @(posedge ENETA_RX_CLK) begin
        if (state == IDLE && start) begin
            cmd_sr <= {`MDIO_OP_READ, phy_addr, reg_addr};
        end else if (cmd_shift) begin
            cmd_sr <= {cmd_sr[cmd_bits-2:0], 1'b0};
        end
        if (state == DATA && mdc_rise) begin
            data_sr <= {data_sr[$bits(phy_data_t)-2:0], mdio_in};
        end
    end

    assign done    = (state == DONE);
    assign rd_data = data_sr;

    a_line_released: assert property (
        @(posedge ENETA_RX_CLK) disable iff (!CPU_RESETn)
        (state == TURNAROUND || state == DATA) |-> !mdio_oe
    );

    // the scan controller waits for done before the next frame
    a_start_when_idle: assert property (
        @(posedge ENETA_RX_CLK) disable iff (!CPU_RESETn)
        start |-> (state == IDLE)
    );

endmodule

// ==== src/phy_scan_ctrl.sv ====
`timescale 1ns/1ps
`include "mdio_defs.svh"

module phy_scan_ctrl
    import mdio_pkg::*;
(
    input  logic          ENETA_RX_CLK,
    input  logic          CPU_RESETn,
    input  logic          done,
    input  phy_data_t     rd_data,
    output logic          start,
    output phy_reg_addr_t reg_addr,
    output logic          wr_en,
    output phy_reg_addr_t wr_addr,
    output phy_data_t     wr_data,
    output logic          scan_done
);

    localparam int wait_w = $clog2(`PHY_POWERUP_CYCLES + 2);
    localparam phy_reg_addr_t last_reg = phy_reg_addr_t'(`PHY_REG_COUNT - 1);

    logic [wait_w-1:0] wait_cnt;
    logic              busy;

    always_ff @(posedge ENETA_RX_CLK) begin
        if (!CPU_RESETn) begin
            wait_cnt  <= wait_w'(`PHY_POWERUP_CYCLES);
            busy      <= 1'b0;
            start     <= 1'b0;
            reg_addr  <= '0;
            scan_done <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wait_cnt != '0) begin
                // PHY still coming out of reset
                wait_cnt <= wait_cnt - 1'b1;
            end else if (busy) begin
                if (done) begin
                    busy <= 1'b0;
                    if (reg_addr == last_reg) begin
                        scan_done <= 1'b1;
                    end else begin
                        reg_addr <= reg_addr + 1'b1;
                    end
                end
            end else if (!scan_done) begin
                start <= 1'b1;
                busy  <= 1'b1;
            end
        end
    end

    // result goes to the bank in the cycle done is seen
    assign wr_en   = done && busy;
    assign wr_addr = reg_addr;
    assign wr_data = rd_data;

endmodule

// ==== src/phy_reg_bank.sv ====
`timescale 1ns/1ps
`include "mdio_defs.svh"

module phy_reg_bank
    import mdio_pkg::*;
(
    input  logic          ENETA_RX_CLK,
    input  logic          CPU_RESETn,
    input  logic          wr_en,
    input  phy_reg_addr_t wr_addr,
    input  phy_data_t     wr_data,
    input  phy_reg_addr_t rd_addr,
    output phy_data_t     rd_data
);

    // one entry per management register
    phy_data_t regs [`PHY_REG_COUNT];

    always_ff @(posedge ENETA_RX_CLK) begin
        if (!CPU_RESETn) begin
            for (int i = 0; i < `PHY_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // read side feeds the dump word directly
    assign rd_data = regs[rd_addr];

endmodule

// ==== src/ram_dump_writer.sv ====
`timescale 1ns/1ps
`include "mdio_defs.svh"

module ram_dump_writer
    import mdio_pkg::*;
(
    input  logic          ENETA_RX_CLK,
    input  logic          CPU_RESETn,
    input  logic          scan_done,
    input  phy_data_t     rd_data,
    output phy_reg_addr_t rd_addr,
    output mem_wr_t       mem_wr,
    output logic          dump_done
);

    localparam int rep_w = $clog2(`DUMP_WRITES_PER_REG + 1);
    localparam int gap_w = $clog2(`DUMP_GAP_CYCLES + 2);
    localparam logic [rep_w-1:0] rep_last = rep_w'(`DUMP_WRITES_PER_REG - 1);
    localparam logic [gap_w-1:0] gap_load = gap_w'(`DUMP_GAP_CYCLES);
    localparam mem_addr_t last_addr = mem_addr_t'(`MEM_DEPTH - 1);
    localparam logic [3:0] tag = `DUMP_TAG;

    mem_addr_t        addr_cnt;
    logic [rep_w-1:0] rep_cnt;
    logic [gap_w-1:0] gap_cnt;
    logic             issue;
    logic             wr_strobe;
    mem_addr_t        wr_addr_q;
    mem_word_t        wr_data_q;
    mem_word_t        word;

    // tag, register number and value in one word
    assign word  = {tag, 3'b000, rd_addr, 4'h0, rd_data};
    assign issue = scan_done && !dump_done && (gap_cnt == '0);

    ////////////////////////////////////////////////////////////////////
    // address, repeat and gap counters
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge ENETA_RX_CLK) begin
        if (!CPU_RESETn) begin
            wr_strobe <= 1'b0;
            dump_done <= 1'b0;
            addr_cnt  <= '0;
            rep_cnt   <= '0;
            gap_cnt   <= '0;
            rd_addr   <= '0;
        end else begin
            wr_strobe <= issue;
            // the gap after the last write keeps it from issuing again
            dump_done <= dump_done || (wr_strobe && wr_addr_q == last_addr);
            if (issue) begin
                gap_cnt  <= gap_load;
                addr_cnt <= addr_cnt + 1'b1;
                if (rep_cnt == rep_last) begin
                    rep_cnt <= '0;
                    // register number wraps from 31 back to 0
                    rd_addr <= rd_addr + 1'b1;
                end else begin
                    rep_cnt <= rep_cnt + 1'b1;
                end
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge ENETA_RX_CLK) begin
        if (issue) begin
            wr_addr_q <= addr_cnt;
            wr_data_q <= word;
        end
    end

    assign mem_wr = '{wr: wr_strobe, addr: wr_addr_q, data: wr_data_q};

    // memory is only touched once the bank is complete
    a_no_early_write: assert property (
        @(posedge ENETA_RX_CLK) disable iff (!CPU_RESETn)
        wr_strobe |-> scan_done
    );

endmodule

// ==== src/phy_mgmt_dump_top.sv ====
`timescale 1ns/1ps

module phy_mgmt_dump_top
    import mdio_pkg::*;
(
    input  logic       ENETA_RX_CLK,
    input  logic       CPU_RESETn,
    input  logic       enet_mdio_in,
    output logic       enet_mdc,
    output logic       enet_mdio_out,
    output logic       enet_mdio_oe,
    output mem_wr_t    mem_wr,
    output logic [1:0] user_led
);

    logic          mdc_rise;
    logic          mdc_fall;
    logic          start;
    logic          done;
    phy_reg_addr_t reg_addr;
    phy_data_t     frame_data;
    logic          bank_wr_en;
    phy_reg_addr_t bank_wr_addr;
    phy_data_t     bank_wr_data;
    phy_reg_addr_t bank_rd_addr;
    phy_data_t     bank_rd_data;
    logic          scan_done;
    logic          dump_done;

    ////////////////////////////////////////////////////////////////////
    // MDIO side
    ////////////////////////////////////////////////////////////////////

    mdc_clock_gen u_mdc_clock_gen (
        .ENETA_RX_CLK (ENETA_RX_CLK),
        .CPU_RESETn   (CPU_RESETn),
        .mdc          (enet_mdc),
        .mdc_rise     (mdc_rise),
        .mdc_fall     (mdc_fall)
    );

    mdio_read_engine u_mdio_read_engine (
        .ENETA_RX_CLK (ENETA_RX_CLK),
        .CPU_RESETn   (CPU_RESETn),
        .mdc_rise     (mdc_rise),
        .mdc_fall     (mdc_fall),
        .start        (start),
        .reg_addr     (reg_addr),
        .mdio_in      (enet_mdio_in),
        .mdio_out     (enet_mdio_out),
        .mdio_oe      (enet_mdio_oe),
        .done         (done),
        .rd_data      (frame_data)
    );

    phy_scan_ctrl u_phy_scan_ctrl (
        .ENETA_RX_CLK (ENETA_RX_CLK),
        .CPU_RESETn   (CPU_RESETn),
        .done         (done),
        .rd_data      (frame_data),
        .start        (start),
        .reg_addr     (reg_addr),
        .wr_en        (bank_wr_en),
        .wr_addr      (bank_wr_addr),
        .wr_data      (bank_wr_data),
        .scan_done    (scan_done)
    );

    ////////////////////////////////////////////////////////////////////
    // storage and memory dump
    ////////////////////////////////////////////////////////////////////

    phy_reg_bank u_phy_reg_bank (
        .ENETA_RX_CLK (ENETA_RX_CLK),
        .CPU_RESETn   (CPU_RESETn),
        .wr_en        (bank_wr_en),
        .wr_addr      (bank_wr_addr),
        .wr_data      (bank_wr_data),
        .rd_addr      (bank_rd_addr),
        .rd_data      (bank_rd_data)
    );

    ram_dump_writer u_ram_dump_writer (
        .ENETA_RX_CLK (ENETA_RX_CLK),
        .CPU_RESETn   (CPU_RESETn),
        .scan_done    (scan_done),
        .rd_data      (bank_rd_data),
        .rd_addr      (bank_rd_addr),
        .mem_wr       (mem_wr),
        .dump_done    (dump_done)
    );

    // LEDs are active low
    assign user_led = {~scan_done, ~dump_done};

endmodule

// ==== dv/phy_mdio_model.sv ====
`timescale 1ns/1ps
`include "mdio_defs.svh"

module phy_mdio_model (
    input  logic              ENETA_RX_CLK,
    input  logic              CPU_RESETn,
    input  logic              mdc,
    input  logic              mdio_out,
    input  logic              mdio_oe,
    input  logic [31:0][15:0] reg_table,
    output logic              mdio_in,
    output logic              frame_strobe,
    output logic [45:0]       frame_bits,
    output logic              resp_strobe,
    output logic              resp_oe
);

    // preamble plus start, opcode, PHY address and register number
    localparam int frame_len = `MDIO_PREAMBLE_BITS + 14;

    logic        mdc_q;
    logic [5:0]  bit_cnt;
    logic [44:0] frame_sr;
    logic        responding;
    logic [4:0]  fall_cnt;
    logic [4:0]  reg_num;
    logic        mdc_rose;
    logic        mdc_fell;

    // MDC edges show up here one clock late
    assign mdc_rose = mdc && !mdc_q;
    assign mdc_fell = !mdc && mdc_q;

    // line idles high through the pull-up
    initial mdio_in = 1'b1;

    always @(posedge ENETA_RX_CLK) begin
        if (!CPU_RESETn) begin
            mdc_q        <= 1'b0;
            bit_cnt      <= '0;
            responding   <= 1'b0;
            fall_cnt     <= '0;
            mdio_in      <= 1'b1;
            frame_strobe <= 1'b0;
            resp_strobe  <= 1'b0;
        end else begin
            mdc_q        <= mdc;
            frame_strobe <= 1'b0;
            resp_strobe  <= 1'b0;
            if (mdc_rose && responding) begin
                resp_strobe <= 1'b1;
                resp_oe     <= mdio_oe;
            end else if (mdc_rose && mdio_oe) begin
                frame_sr <= {frame_sr[43:0], mdio_out};
                if (bit_cnt == 6'(frame_len - 1)) begin
                    bit_cnt      <= '0;
                    responding   <= 1'b1;
                    fall_cnt     <= '0;
                    frame_strobe <= 1'b1;
                    frame_bits   <= {frame_sr[44:0], mdio_out};
                    reg_num      <= {frame_sr[3:0], mdio_out};
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
            // the PHY leaves the first turnaround bit released and drives the second low
            if (mdc_fell && responding) begin
                fall_cnt <= fall_cnt + 1'b1;
                if (fall_cnt == 5'd1) begin
                    mdio_in <= 1'b0;
                end else if (fall_cnt >= 5'd2 && fall_cnt <= 5'd17) begin
                    mdio_in <= reg_table[reg_num][5'd17 - fall_cnt];
                end else if (fall_cnt == 5'd18) begin
                    mdio_in    <= 1'b1;
                    responding <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== dv/tb_phy_mgmt_dump.sv ====
`timescale 1ns/1ps
`include "mdio_defs.svh"

module tb_phy_mgmt_dump
    import mdio_pkg::*;
();

    localparam int scan_limit = `PHY_POWERUP_CYCLES + `PHY_REG_COUNT * 800;
    localparam int dump_limit = `MEM_DEPTH * (`DUMP_GAP_CYCLES + 1) + 1000;
    localparam int quiet_cycles = 2000;

    logic              ENETA_RX_CLK;
    logic              CPU_RESETn;
    logic              enet_mdio_in;
    logic              enet_mdc;
    logic              enet_mdio_out;
    logic              enet_mdio_oe;
    mem_wr_t           mem_wr;
    logic [1:0]        user_led;
    logic [31:0][15:0] reg_table;
    logic              frame_strobe;
    logic [45:0]       frame_bits;
    logic              resp_strobe;
    logic              resp_oe;
    integer            seed;
    int                cycle_cnt;
    int                write_count;
    int                last_write_cycle;
    int                frame_count;
    int                resp_count;
    int                last_rise_cycle;
    logic              mdc_q;

    phy_mgmt_dump_top u_phy_mgmt_dump_top (
        .ENETA_RX_CLK  (ENETA_RX_CLK),
        .CPU_RESETn    (CPU_RESETn),
        .enet_mdio_in  (enet_mdio_in),
        .enet_mdc      (enet_mdc),
        .enet_mdio_out (enet_mdio_out),
        .enet_mdio_oe  (enet_mdio_oe),
        .mem_wr        (mem_wr),
        .user_led      (user_led)
    );

    phy_mdio_model u_phy_mdio_model (
        .ENETA_RX_CLK (ENETA_RX_CLK),
        .CPU_RESETn   (CPU_RESETn),
        .mdc          (enet_mdc),
        .mdio_out     (enet_mdio_out),
        .mdio_oe      (enet_mdio_oe),
        .reg_table    (reg_table),
        .mdio_in      (enet_mdio_in),
        .frame_strobe (frame_strobe),
        .frame_bits   (frame_bits),
        .resp_strobe  (resp_strobe),
        .resp_oe      (resp_oe)
    );

    initial ENETA_RX_CLK = 1'b0;
    always #10 ENETA_RX_CLK = ~ENETA_RX_CLK;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "%s", reason);
    endtask

    // tag, register number and that register's PHY value for word n
    function automatic mem_word_t expected_word(input int n);
        int reg_num;
        reg_num = (n / `DUMP_WRITES_PER_REG) % `PHY_REG_COUNT;
        return {`DUMP_TAG, 3'b000, reg_num[4:0], 4'h0, reg_table[reg_num]};
    endfunction

    ////////////////////////////////////////////////////////////////////
    // monitors on MDC/MDIO and the memory write port
    ////////////////////////////////////////////////////////////////////

    always @(posedge ENETA_RX_CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        mdc_q     <= enet_mdc;
        if (CPU_RESETn && enet_mdc && !mdc_q) begin
            if (enet_mdio_oe && last_rise_cycle >= 0) begin
                check_value("enet_mdc period", cycle_cnt - last_rise_cycle,
                            2 * `MDC_HALF_PERIOD);
            end
            last_rise_cycle <= cycle_cnt;
        end
        if (frame_strobe) begin
            if (frame_count >= `PHY_REG_COUNT) begin
                stop_run("more management frames than registers");
            end
            check_value("enet_mdio_out preamble", frame_bits[45:14], 32'hffff_ffff);
            check_value("enet_mdio_out opcode", frame_bits[13:10], `MDIO_OP_READ);
            check_value("enet_mdio_out phy address", frame_bits[9:5], `PHY_ADDR);
            check_value("enet_mdio_out register", frame_bits[4:0], frame_count[4:0]);
            frame_count <= frame_count + 1;
        end
        if (resp_strobe) begin
            check_value("enet_mdio_oe", resp_oe, 1'b0);
            resp_count <= resp_count + 1;
        end
    end

    always @(posedge ENETA_RX_CLK) begin
        if (CPU_RESETn && mem_wr.wr) begin
            if (user_led[1] !== 1'b0) begin
                stop_run("memory write seen before the register scan finished");
            end
            if (write_count >= `MEM_DEPTH) begin
                stop_run("memory write seen after the last address was written");
            end
            check_value("mem_wr.addr", mem_wr.addr, mem_addr_t'(write_count));
            check_value("mem_wr.data", mem_wr.data, expected_word(write_count));
            if (write_count > 0) begin
                check_value("mem_wr spacing", cycle_cnt - last_write_cycle,
                            `DUMP_GAP_CYCLES + 1);
            end
            write_count      <= write_count + 1;
            last_write_cycle <= cycle_cnt;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // reset, scan and dump sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        int wait_cycles;
        seed            = 32'h3a45_35a7;
        cycle_cnt       = 0;
        write_count     = 0;
        frame_count     = 0;
        resp_count      = 0;
        last_rise_cycle = -1;
        CPU_RESETn      = 1'b0;
        for (int i = 0; i < `PHY_REG_COUNT; i++) begin
            reg_table[i] = 16'($random(seed));
        end
        repeat (16) @(posedge ENETA_RX_CLK);
        check_value("enet_mdc", enet_mdc, 1'b0);
        check_value("enet_mdio_oe", enet_mdio_oe, 1'b0);
        check_value("mem_wr.wr", mem_wr.wr, 1'b0);
        check_value("user_led", user_led, 2'b11);
        CPU_RESETn <= 1'b1;

        wait_cycles = 0;
        while (user_led[1] !== 1'b0) begin
            @(posedge ENETA_RX_CLK);
            wait_cycles++;
            if (wait_cycles > scan_limit) begin
                stop_run("timeout waiting for the register scan to finish");
            end
        end
        check_value("frame count", frame_count, `PHY_REG_COUNT);

        wait_cycles = 0;
        while (user_led[0] !== 1'b0) begin
            @(posedge ENETA_RX_CLK);
            wait_cycles++;
            if (wait_cycles > dump_limit) begin
                stop_run("timeout waiting for the memory dump to finish");
            end
        end
        check_value("write count", write_count, `MEM_DEPTH);
        check_value("user_led", user_led, 2'b00);
        // two turnaround bits and 16 data bits per frame
        check_value("released bit count", resp_count, `PHY_REG_COUNT * 18);

        // no writes may follow the dump
        wait_cycles = 0;
        while (wait_cycles < quiet_cycles) begin
            @(posedge ENETA_RX_CLK);
            wait_cycles++;
        end
        check_value("user_led", user_led, 2'b00);
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
src/mdio_pkg.sv
src/mdc_clock_gen.sv
src/mdio_read_engine.sv
src/phy_scan_ctrl.sv
src/phy_reg_bank.sv
src/ram_dump_writer.sv
src/phy_mgmt_dump_top.sv
dv/phy_mdio_model.sv
dv/tb_phy_mgmt_dump.sv
